// File: flist.f
rtl/ddr_pkg.sv
rtl/ddr_app_mem.sv
rtl/ddr_app_arbiter.sv
rtl/ddr_traffic_gen.sv
rtl/ddr_subsys_top.sv
tb/ddr_clk_gen.sv
tb/ddr_subsys_tb.sv

// File: rtl/ddr_app_arbiter.sv
module ddr_app_arbiter import ddr_pkg::*; (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  input  logic                      app_rdy_i,
  input  logic                      tg_req_i,
  input  logic                      tg_we_i,
  input  logic [APP_ADDR_WIDTH-1:0] tg_addr_i,
  input  logic [APP_DATA_WIDTH-1:0] tg_wdata_i,
  input  logic                      host_req_i,
  input  logic                      host_we_i,
  input  logic [APP_ADDR_WIDTH-1:0] host_addr_i,
  input  logic [APP_DATA_WIDTH-1:0] host_wdata_i,
  input  logic                      app_rd_valid_i,
  input  logic [APP_DATA_WIDTH-1:0] app_rd_data_i,
  input  logic [REQ_ID_WIDTH-1:0]   app_rd_id_i,
  output logic                      tg_gnt_o,
  output logic                      tg_rvalid_o,
  output logic [APP_DATA_WIDTH-1:0] tg_rdata_o,
  output logic                      host_gnt_o,
  output logic                      host_rvalid_o,
  output logic [APP_DATA_WIDTH-1:0] host_rdata_o,
  output logic                      app_en_o,
  output logic                      app_we_o,
  output logic [APP_ADDR_WIDTH-1:0] app_addr_o,
  output logic [APP_DATA_WIDTH-1:0] app_wdata_o,
  output logic [REQ_ID_WIDTH-1:0]   app_id_o
);

  logic last_host_q;
  logic tg_win;
  logic host_win;

  // On a tie the requester not served last wins
  assign tg_win   = tg_req_i && (!host_req_i || last_host_q);
  assign host_win = host_req_i && (!tg_req_i || !last_host_q);

  assign tg_gnt_o   = app_rdy_i && tg_win;
  assign host_gnt_o = app_rdy_i && host_win;

  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      last_host_q <= 1'b1;
    end else if (tg_gnt_o) begin
      last_host_q <= 1'b0;
    end else if (host_gnt_o) begin
      last_host_q <= 1'b1;
    end
  end

  // **************************************************
  // Command mux toward the memory
  // **************************************************
  assign app_en_o    = tg_gnt_o || host_gnt_o;
  assign app_we_o    = host_gnt_o ? host_we_i : tg_we_i;
  assign app_addr_o  = host_gnt_o ? host_addr_i : tg_addr_i;
  assign app_wdata_o = host_gnt_o ? host_wdata_i : tg_wdata_i;
  assign app_id_o    = host_gnt_o ? REQ_ID_HOST : REQ_ID_TG;

  // Read returns steered back by the tag that went out with the command
  assign tg_rvalid_o   = app_rd_valid_i && (app_rd_id_i == REQ_ID_TG);
  assign host_rvalid_o = app_rd_valid_i && (app_rd_id_i == REQ_ID_HOST);
  assign tg_rdata_o    = app_rd_data_i;
  assign host_rdata_o  = app_rd_data_i;

  a_grant_onehot: assert property (
    @(posedge c0_ddr4_clk) disable iff (reset_i)
    !(tg_gnt_o && host_gnt_o)
  );

  a_no_grant_unready: assert property (
    @(posedge c0_ddr4_clk) disable iff (reset_i)
    !app_rdy_i |-> !(tg_gnt_o || host_gnt_o)
  );

endmodule

// File: rtl/ddr_app_mem.sv
module ddr_app_mem import ddr_pkg::*; (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  input  logic                      app_en_i,
  input  logic                      app_we_i,
  input  logic [APP_ADDR_WIDTH-1:0] app_addr_i,
  input  logic [APP_DATA_WIDTH-1:0] app_wdata_i,
  input  logic [REQ_ID_WIDTH-1:0]   app_id_i,
  output logic                      app_rdy_o,
  output logic                      init_calib_complete_o,
  output logic                      app_rd_valid_o,
  output logic [APP_DATA_WIDTH-1:0] app_rd_data_o,
  output logic [REQ_ID_WIDTH-1:0]   app_rd_id_o
);

  logic [CALIB_CNT_WIDTH-1:0] calib_cnt_q;
  logic                       calib_q;
  logic [APP_DATA_WIDTH-1:0]  mem_q [2**APP_ADDR_WIDTH];
  logic [READ_LATENCY-1:0]    rd_vld_q;
  logic [APP_DATA_WIDTH-1:0]  rd_data_q [READ_LATENCY];
  logic [REQ_ID_WIDTH-1:0]    rd_id_q [READ_LATENCY];
  logic                       cmd_acc;
  logic                       rd_acc;

  // **************************************************
  // Calibration
  // **************************************************
  // Counts cycles out of reset, then stays done
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      calib_cnt_q <= '0;
      calib_q     <= 1'b0;
    end else if (!calib_q) begin
      if (calib_cnt_q == CALIB_CNT_WIDTH'(CALIB_CYCLES - 1)) begin
        calib_q <= 1'b1;
      end else begin
        calib_cnt_q <= calib_cnt_q + 1'b1;
      end
    end
  end

  assign init_calib_complete_o = calib_q;
  assign app_rdy_o             = calib_q;

  assign cmd_acc = app_en_i && calib_q;
  assign rd_acc  = cmd_acc && !app_we_i;

  // **************************************************
  // Storage and read pipeline
  // **************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (cmd_acc && app_we_i) begin
      mem_q[app_addr_i] <= app_wdata_i;
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      rd_vld_q <= '0;
    end else begin
      rd_vld_q <= {rd_vld_q[READ_LATENCY-2:0], rd_acc};
    end
  end

  // Stage 0 samples the array as it was before this edge
  always_ff @(posedge c0_ddr4_clk) begin
    rd_data_q[0] <= mem_q[app_addr_i];
    rd_id_q[0]   <= app_id_i;
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_data_q[i] <= rd_data_q[i-1];
      rd_id_q[i]   <= rd_id_q[i-1];
    end
  end

  assign app_rd_valid_o = rd_vld_q[READ_LATENCY-1];
  assign app_rd_data_o  = rd_data_q[READ_LATENCY-1];
  assign app_rd_id_o    = rd_id_q[READ_LATENCY-1];

  // Upstream must hold off every command until calibration is done
  a_no_cmd_before_calib: assert property (
    @(posedge c0_ddr4_clk) disable iff (reset_i)
    app_en_i |-> init_calib_complete_o
  );

endmodule

// File: rtl/ddr_pkg.sv
package ddr_pkg;

  // **************************************************
  // Application interface geometry
  // **************************************************
  localparam int APP_ADDR_WIDTH = 10;
  localparam int APP_DATA_WIDTH = 64;

  // Requester tag carried through the memory with each read
  localparam int REQ_ID_WIDTH = 1;
  localparam logic [REQ_ID_WIDTH-1:0] REQ_ID_TG = 1'b0;
  localparam logic [REQ_ID_WIDTH-1:0] REQ_ID_HOST = 1'b1;

  // **************************************************
  // Controller timing
  // **************************************************
  localparam int CALIB_CYCLES = 16;
  localparam int CALIB_CNT_WIDTH = $clog2(CALIB_CYCLES);
  localparam int READ_LATENCY = 4;

  // **************************************************
  // Traffic generator region and pattern
  // **************************************************
  localparam logic [APP_ADDR_WIDTH-1:0] TG_BASE = 10'h100;
  localparam int TG_WORDS = 16;
  // Wide enough to count one past the last word
  localparam int TG_CNT_WIDTH = $clog2(TG_WORDS + 1);
  // Word at address a is a XOR this value
  localparam logic [APP_DATA_WIDTH-1:0] TG_PATTERN = 64'hC0DE_5A5A_A5A5_0F0F;

endpackage

// File: rtl/ddr_subsys_top.sv
module ddr_subsys_top import ddr_pkg::*; (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  input  logic                      tg_start_i,
  input  logic                      tg_verify_only_i,
  input  logic                      host_req_i,
  input  logic                      host_we_i,
  input  logic [APP_ADDR_WIDTH-1:0] host_addr_i,
  input  logic [APP_DATA_WIDTH-1:0] host_wdata_i,
  output logic                      host_gnt_o,
  output logic                      host_rvalid_o,
  output logic [APP_DATA_WIDTH-1:0] host_rdata_o,
  output logic                      tg_done_o,
  output logic                      c0_init_calib_complete,
  output logic                      c0_data_compare_error
);

  // Generator to arbiter
  logic                      tg_req;
  logic                      tg_we;
  logic [APP_ADDR_WIDTH-1:0] tg_addr;
  logic [APP_DATA_WIDTH-1:0] tg_wdata;
  logic                      tg_gnt;
  logic                      tg_rvalid;
  logic [APP_DATA_WIDTH-1:0] tg_rdata;

  // Arbiter to memory
  logic                      app_en;
  logic                      app_we;
  logic [APP_ADDR_WIDTH-1:0] app_addr;
  logic [APP_DATA_WIDTH-1:0] app_wdata;
  logic [REQ_ID_WIDTH-1:0]   app_id;
  logic                      app_rdy;
  logic                      app_rd_valid;
  logic [APP_DATA_WIDTH-1:0] app_rd_data;
  logic [REQ_ID_WIDTH-1:0]   app_rd_id;

  ddr_traffic_gen u_ddr_traffic_gen (
    .c0_ddr4_clk     (c0_ddr4_clk),
    .reset_i         (reset_i),
    .start_i         (tg_start_i),
    .verify_only_i   (tg_verify_only_i),
    .calib_done_i    (c0_init_calib_complete),
    .gnt_i           (tg_gnt),
    .rvalid_i        (tg_rvalid),
    .rdata_i         (tg_rdata),
    .req_o           (tg_req),
    .we_o            (tg_we),
    .addr_o          (tg_addr),
    .wdata_o         (tg_wdata),
    .done_o          (tg_done_o),
    .compare_error_o (c0_data_compare_error)
  );

  ddr_app_arbiter u_ddr_app_arbiter (
    .c0_ddr4_clk    (c0_ddr4_clk),
    .reset_i        (reset_i),
    .app_rdy_i      (app_rdy),
    .tg_req_i       (tg_req),
    .tg_we_i        (tg_we),
    .tg_addr_i      (tg_addr),
    .tg_wdata_i     (tg_wdata),
    .host_req_i     (host_req_i),
    .host_we_i      (host_we_i),
    .host_addr_i    (host_addr_i),
    .host_wdata_i   (host_wdata_i),
    .app_rd_valid_i (app_rd_valid),
    .app_rd_data_i  (app_rd_data),
    .app_rd_id_i    (app_rd_id),
    .tg_gnt_o       (tg_gnt),
    .tg_rvalid_o    (tg_rvalid),
    .tg_rdata_o     (tg_rdata),
    .host_gnt_o     (host_gnt_o),
    .host_rvalid_o  (host_rvalid_o),
    .host_rdata_o   (host_rdata_o),
    .app_en_o       (app_en),
    .app_we_o       (app_we),
    .app_addr_o     (app_addr),
    .app_wdata_o    (app_wdata),
    .app_id_o       (app_id)
  );

  ddr_app_mem u_ddr_app_mem (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .reset_i               (reset_i),
    .app_en_i              (app_en),
    .app_we_i              (app_we),
    .app_addr_i            (app_addr),
    .app_wdata_i           (app_wdata),
    .app_id_i              (app_id),
    .app_rdy_o             (app_rdy),
    .init_calib_complete_o (c0_init_calib_complete),
    .app_rd_valid_o        (app_rd_valid),
    .app_rd_data_o         (app_rd_data),
    .app_rd_id_o           (app_rd_id)
  );

endmodule

// File: rtl/ddr_traffic_gen.sv
module ddr_traffic_gen import ddr_pkg::*; (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  input  logic                      start_i,
  input  logic                      verify_only_i,
  input  logic                      calib_done_i,
  input  logic                      gnt_i,
  input  logic                      rvalid_i,
  input  logic [APP_DATA_WIDTH-1:0] rdata_i,
  output logic                      req_o,
  output logic                      we_o,
  output logic [APP_ADDR_WIDTH-1:0] addr_o,
  output logic [APP_DATA_WIDTH-1:0] wdata_o,
  output logic                      done_o,
  output logic                      compare_error_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_WAIT
  } tg_state_e;

  tg_state_e                 state_q;
  logic [TG_CNT_WIDTH-1:0]   iss_cnt_q;
  logic [TG_CNT_WIDTH-1:0]   ret_cnt_q;
  logic                      done_q;
  logic                      err_q;
  logic                      start_acc;
  logic                      last_iss;
  logic                      last_ret;
  logic [APP_ADDR_WIDTH-1:0] ret_addr;
  logic [APP_DATA_WIDTH-1:0] exp_data;

  function automatic logic [APP_DATA_WIDTH-1:0] pattern_word(
    input logic [APP_ADDR_WIDTH-1:0] addr
  );
    return APP_DATA_WIDTH'(addr) ^ TG_PATTERN;
  endfunction

  assign start_acc = start_i && calib_done_i && (state_q == ST_IDLE);
  assign last_iss  = iss_cnt_q == TG_CNT_WIDTH'(TG_WORDS - 1);
  assign last_ret  = rvalid_i && (ret_cnt_q == TG_CNT_WIDTH'(TG_WORDS - 1));

  // Request side, held steady until granted
  assign req_o   = (state_q == ST_WRITE) || (state_q == ST_READ);
  assign we_o    = state_q == ST_WRITE;
  assign addr_o  = TG_BASE + APP_ADDR_WIDTH'(iss_cnt_q);
  assign wdata_o = pattern_word(addr_o);

  // Returns arrive in issue order
  assign ret_addr = TG_BASE + APP_ADDR_WIDTH'(ret_cnt_q);
  assign exp_data = pattern_word(ret_addr);

  assign done_o          = done_q;
  assign compare_error_o = err_q;

  // **************************************************
  // Sequencer
  // **************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      iss_cnt_q <= '0;
      ret_cnt_q <= '0;
      done_q    <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_acc) begin
            err_q     <= 1'b0;
            iss_cnt_q <= '0;
            ret_cnt_q <= '0;
            state_q   <= verify_only_i ? ST_READ : ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (gnt_i) begin
            if (last_iss) begin
              iss_cnt_q <= '0;
              state_q   <= ST_READ;
            end else begin
              iss_cnt_q <= iss_cnt_q + 1'b1;
            end
          end
        end
        ST_READ: begin
          if (gnt_i) begin
            iss_cnt_q <= iss_cnt_q + 1'b1;
            if (last_iss) begin
              state_q <= ST_WAIT;
            end
          end
        end
        ST_WAIT: begin
          // Drain the reads still in the memory pipeline
          if (last_ret) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase

      // Compare runs alongside issue, reads overlap in the pipeline
      if (rvalid_i) begin
        ret_cnt_q <= ret_cnt_q + 1'b1;
        if (rdata_i != exp_data) begin
          err_q <= 1'b1;
        end
      end
    end
  end

  // Arbiter routing must only hand back reads this block issued
  a_no_orphan_return: assert property (
    @(posedge c0_ddr4_clk) disable iff (reset_i)
    rvalid_i |-> (state_q inside {ST_READ, ST_WAIT}) && (ret_cnt_q < iss_cnt_q)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the DDR subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f flist.f --top-module ddr_subsys_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vddr_subsys_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF "All tests passed!"; then
  exit 0
fi
exit 1

// File: tb/ddr_clk_gen.sv
module ddr_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  // 40 time unit period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset held over two rising edges, released like any other input
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #5;
    reset_o = 1'b0;
  end

endmodule

// File: tb/ddr_subsys_tb.sv
module ddr_subsys_tb import ddr_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int HOST_WORDS = 8;

  logic                      c0_ddr4_clk;
  logic                      reset_i;
  logic                      tg_start;
  logic                      tg_verify_only;
  logic                      host_req;
  logic                      host_we;
  logic [APP_ADDR_WIDTH-1:0] host_addr;
  logic [APP_DATA_WIDTH-1:0] host_wdata;
  logic                      host_gnt_o;
  logic                      host_rvalid_o;
  logic [APP_DATA_WIDTH-1:0] host_rdata_o;
  logic                      tg_done_o;
  logic                      c0_init_calib_complete;
  logic                      c0_data_compare_error;

  // Reference model and expected read returns
  logic [APP_DATA_WIDTH-1:0] model_mem [int];
  logic [READ_LATENCY-1:0]   host_rd_pipe;
  logic [APP_DATA_WIDTH-1:0] exp_pipe [READ_LATENCY];
  logic                      tg_exp_err;
  int                        cycle_cnt;
  int                        since_rst;
  int                        host_wait;

  ddr_clk_gen u_ddr_clk_gen (
    .clk_o   (c0_ddr4_clk),
    .reset_o (reset_i)
  );

  ddr_subsys_top u_ddr_subsys_top (
    .c0_ddr4_clk            (c0_ddr4_clk),
    .reset_i                (reset_i),
    .tg_start_i             (tg_start),
    .tg_verify_only_i       (tg_verify_only),
    .host_req_i             (host_req),
    .host_we_i              (host_we),
    .host_addr_i            (host_addr),
    .host_wdata_i           (host_wdata),
    .host_gnt_o             (host_gnt_o),
    .host_rvalid_o          (host_rvalid_o),
    .host_rdata_o           (host_rdata_o),
    .tg_done_o              (tg_done_o),
    .c0_init_calib_complete (c0_init_calib_complete),
    .c0_data_compare_error  (c0_data_compare_error)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [APP_DATA_WIDTH-1:0] got,
                                 input logic [APP_DATA_WIDTH-1:0] exp);
    abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic int tg_addr(input int k);
    return int'(TG_BASE) + k;
  endfunction

  // Generator rule: word at address a is a XOR the pattern
  function automatic logic [APP_DATA_WIDTH-1:0] tg_word(input int k);
    return APP_DATA_WIDTH'(tg_addr(k)) ^ TG_PATTERN;
  endfunction

  function automatic logic region_mismatch();
    logic bad;
    bad = 1'b0;
    for (int k = 0; k < TG_WORDS; k++) begin
      if (!model_mem.exists(tg_addr(k)) || model_mem[tg_addr(k)] != tg_word(k)) begin
        bad = 1'b1;
      end
    end
    return bad;
  endfunction

  // **************************************************
  // Bookkeeping at each rising edge
  // **************************************************
  always @(posedge c0_ddr4_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the run went past its cycle limit");
    end
  end

  always @(posedge c0_ddr4_clk) begin
    since_rst <= reset_i ? 0 : since_rst + 1;
    if (reset_i || !host_req || host_gnt_o || !c0_init_calib_complete) begin
      host_wait <= 0;
    end else begin
      host_wait <= host_wait + 1;
    end
  end

  always @(posedge c0_ddr4_clk) begin
    if (host_req && host_gnt_o && host_we) begin
      model_mem[int'(host_addr)] = host_wdata;
    end
    host_rd_pipe <= reset_i ? '0 : {host_rd_pipe[READ_LATENCY-2:0],
                                    host_req && host_gnt_o && !host_we};
    exp_pipe[0] <= model_mem.exists(int'(host_addr)) ? model_mem[int'(host_addr)] : '0;
    for (int i = 1; i < READ_LATENCY; i++) begin
      exp_pipe[i] <= exp_pipe[i-1];
    end
  end

  // **************************************************
  // Checks
  // **************************************************
  a_reset_quiet: assert property (@(posedge c0_ddr4_clk)
    reset_i && $past(reset_i) |->
      {c0_init_calib_complete, host_gnt_o, host_rvalid_o, tg_done_o,
       c0_data_compare_error} == 5'b0)
    else report_mismatch("outputs in reset",
      APP_DATA_WIDTH'({c0_init_calib_complete, host_gnt_o, host_rvalid_o, tg_done_o,
                       c0_data_compare_error}), '0);

  // Calibration completes a fixed count after release
  a_calib_time: assert property (@(posedge c0_ddr4_clk) disable iff (reset_i)
    c0_init_calib_complete == (since_rst >= CALIB_CYCLES))
    else report_mismatch("c0_init_calib_complete", APP_DATA_WIDTH'(c0_init_calib_complete),
      APP_DATA_WIDTH'(since_rst >= CALIB_CYCLES));

  a_no_early_grant: assert property (@(posedge c0_ddr4_clk)
    host_gnt_o |-> c0_init_calib_complete)
    else abort_run("Host was granted before calibration completed");

  a_grant_delay: assert property (@(posedge c0_ddr4_clk) disable iff (reset_i)
    host_req && c0_init_calib_complete && !host_gnt_o |-> host_wait == 0)
    else abort_run("Host request was not granted within two cycles");

  a_rvalid_time: assert property (@(posedge c0_ddr4_clk) disable iff (reset_i)
    host_rvalid_o == host_rd_pipe[READ_LATENCY-1])
    else report_mismatch("host_rvalid_o", APP_DATA_WIDTH'(host_rvalid_o),
      APP_DATA_WIDTH'(host_rd_pipe[READ_LATENCY-1]));

  a_rdata: assert property (@(posedge c0_ddr4_clk) disable iff (reset_i)
    host_rvalid_o |-> host_rdata_o == exp_pipe[READ_LATENCY-1])
    else report_mismatch("host_rdata_o", host_rdata_o, exp_pipe[READ_LATENCY-1]);

  a_tg_result: assert property (@(posedge c0_ddr4_clk) disable iff (reset_i)
    tg_done_o |-> c0_data_compare_error == tg_exp_err)
    else report_mismatch("c0_data_compare_error", APP_DATA_WIDTH'(c0_data_compare_error),
      APP_DATA_WIDTH'(tg_exp_err));

  // **************************************************
  // Stimulus
  // **************************************************
  task automatic host_access(input logic we, input logic [APP_ADDR_WIDTH-1:0] addr,
                             input logic [APP_DATA_WIDTH-1:0] wdata);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    do @(negedge c0_ddr4_clk); while (!host_gnt_o);
    @(posedge c0_ddr4_clk);
    #5;
    host_req = 1'b0;
  endtask

  task automatic drain_host_reads();
    while (host_rd_pipe != '0) @(negedge c0_ddr4_clk);
    @(posedge c0_ddr4_clk);
    #5;
  endtask

  // Writes to random low addresses, then reads them back to back
  task automatic host_random_rw(input int n);
    logic [APP_ADDR_WIDTH-1:0] addrs [$];
    logic [APP_ADDR_WIDTH-1:0] a;
    for (int i = 0; i < n; i++) begin
      a = APP_ADDR_WIDTH'($urandom_range(255, 0));
      addrs.push_back(a);
      host_access(1'b1, a, {$urandom, $urandom});
    end
    foreach (addrs[i]) begin
      host_access(1'b0, addrs[i], '0);
    end
    drain_host_reads();
  endtask

  task automatic run_tg(input logic verify_only);
    if (!verify_only) begin
      for (int k = 0; k < TG_WORDS; k++) begin
        model_mem[tg_addr(k)] = tg_word(k);
      end
    end
    tg_exp_err     = region_mismatch();
    tg_verify_only = verify_only;
    tg_start       = 1'b1;
    @(posedge c0_ddr4_clk);
    #5;
    tg_start = 1'b0;
    do @(negedge c0_ddr4_clk); while (!tg_done_o);
    @(posedge c0_ddr4_clk);
    #5;
  endtask

  initial begin
    void'($urandom(53));
    tg_start       = 1'b0;
    tg_verify_only = 1'b0;
    tg_exp_err     = 1'b0;
    host_we        = 1'b0;
    host_addr      = '0;
    host_wdata     = '0;
    host_req       = 1'b0;

    // Write held from reset, granted only after calibration
    host_access(1'b1, 10'h0A5, 64'h0123_4567_89AB_CDEF);
    host_random_rw(HOST_WORDS);

    run_tg(1'b0);
    for (int k = 0; k < TG_WORDS; k++) begin
      host_access(1'b0, APP_ADDR_WIDTH'(tg_addr(k)), '0);
    end
    drain_host_reads();

    // Host traffic competes with a full generator pass
    fork
      run_tg(1'b0);
      host_random_rw(HOST_WORDS);
    join

    // Corrupt one generator word, verify, then rewrite
    host_access(1'b1, APP_ADDR_WIDTH'(tg_addr(5)), tg_word(5) ^ 64'h1);
    run_tg(1'b1);
    run_tg(1'b0);

    $display("All tests passed!");
    $finish;
  end

endmodule
